// ==== fir_pkg.sv ====
package fir_pkg;

	// Filter geometry.
	localparam int NUM_TAPS = 13;
	localparam int SAMPLE_W = 16;
	localparam int COEF_W = 16;

	// Thirteen full-scale products need 32 + 4 bits, so the sum never wraps.
	localparam int ACC_W = 36;
	localparam int TAP_IDX_W = 4;

	// Width of one raw product before it is widened to the accumulator.
	localparam int PROD_W = SAMPLE_W + COEF_W;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [TAP_IDX_W-1:0] tap_idx_t;

	// Element 0 holds the newest sample and element NUM_TAPS-1 the oldest.
	typedef sample_t [NUM_TAPS-1:0] tap_array_t;

	localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

	// Coefficient k multiplies tap k.
	localparam coef_t COEFS [NUM_TAPS] = '{
		-16'sd112,
		-16'sd245,
		16'sd187,
		16'sd903,
		16'sd1834,
		16'sd3071,
		16'sd4096,
		16'sd2950,
		16'sd1701,
		16'sd840,
		16'sd233,
		-16'sd198,
		-16'sd87
	};

	// Commands from the control FSM to the multiply-accumulate unit.
	typedef struct packed {
		logic clear;
		logic accumulate;
	} mac_ctrl_t;

endpackage

// ==== tap_delay_line.sv ====
module tap_delay_line
	import fir_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       shift_en,
	input  sample_t    sample,
	output tap_array_t taps
);

	// The taps are cleared on reset so the first outputs of the filter
	// only see the samples that really arrived.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps <= '0;
		end else if (shift_en) begin
			// The new sample lands in stage 0 and every older stage moves up by one.
			// The oldest sample drops out of the top.
			taps <= {taps[NUM_TAPS-2:0], sample};
		end
	end

endmodule

// ==== tap_counter.sv ====
module tap_counter
	import fir_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     start,
	output tap_idx_t tap_index,
	output logic     count_last
);

	logic active;

	// The index sits at 0 while idle, so the first tap is ready in the
	// cycle right after start.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active <= 1'b0;
			tap_index <= '0;
		end else if (start) begin
			active <= 1'b1;
			tap_index <= '0;
		end else if (active) begin
			if (tap_index == LAST_TAP) begin
				active <= 1'b0;
				tap_index <= '0;
			end else begin
				tap_index <= tap_index + 1'b1;
			end
		end
	end

	assign count_last = active && (tap_index == LAST_TAP);

	a_index_range: assert property (@(posedge clk) disable iff (reset)
		tap_index <= LAST_TAP)
		else $error("tap_counter: tap_index %0d is past the last tap", tap_index);

	// A second start would cut the running sum short.
	a_no_restart: assert property (@(posedge clk) disable iff (reset)
		start |-> !active)
		else $error("tap_counter: start arrived while a count was running");

endmodule

// ==== mac_unit.sv ====
module mac_unit
	import fir_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  mac_ctrl_t  mac_ctrl,
	input  tap_idx_t   tap_index,
	input  tap_array_t taps,
	output acc_t       result
);

	sample_t                   sel_tap;
	coef_t                     sel_coef;
	logic signed [PROD_W-1:0]  product;
	acc_t                      product_ext;
	acc_t                      acc;
	acc_t                      acc_sum;
	logic                      last_add;

	// One tap and its coefficient are picked each cycle.
	always_comb begin
		sel_tap = taps[tap_index];
		sel_coef = COEFS[tap_index];
	end

	// Both operands are signed, so the product and its widening keep the sign.
	always_comb begin
		product = sel_tap * sel_coef;
		product_ext = acc_t'(product);
		acc_sum = acc + product_ext;
	end

	assign last_add = mac_ctrl.accumulate && (tap_index == LAST_TAP);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc <= '0;
		end else if (mac_ctrl.clear) begin
			acc <= '0;
		end else if (mac_ctrl.accumulate) begin
			acc <= acc_sum;
		end
	end

	// The result register takes the finished sum together with the final
	// add and keeps it while the next sample is being shifted in.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			result <= '0;
		end else if (last_add) begin
			result <= acc_sum;
		end
	end

	a_ctrl_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mac_ctrl.clear && mac_ctrl.accumulate))
		else $error("mac_unit: clear and accumulate are both high");

endmodule

// ==== fir_control.sv ====
module fir_control
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      in_req,
	output logic      in_ack,
	output logic      out_req,
	input  logic      out_ack,
	output logic      shift_en,
	output logic      count_start,
	input  logic      count_last,
	output mac_ctrl_t mac_ctrl
);

	typedef enum logic [2:0] {
		IDLE,
		SHIFT,
		ACK_IN,
		START,
		ACCUM,
		OUT_REQ,
		OUT_WAIT
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// IDLE is only reached once the previous result has been taken, which
	// is what holds off the producer while the consumer is slow.
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (in_req) begin
					state_next = SHIFT;
				end
			end
			SHIFT: begin
				state_next = ACK_IN;
			end
			ACK_IN: begin
				if (!in_req) begin
					state_next = START;
				end
			end
			START: begin
				state_next = ACCUM;
			end
			ACCUM: begin
				if (count_last) begin
					state_next = OUT_REQ;
				end
			end
			OUT_REQ: begin
				if (out_ack) begin
					state_next = OUT_WAIT;
				end
			end
			OUT_WAIT: begin
				if (!out_ack) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	// Every output comes straight from the state register.
	always_comb begin
		in_ack = 1'b0;
		out_req = 1'b0;
		shift_en = 1'b0;
		count_start = 1'b0;
		mac_ctrl = '0;
		case (state)
			SHIFT: begin
				shift_en = 1'b1;
				mac_ctrl.clear = 1'b1;
			end
			ACK_IN: begin
				in_ack = 1'b1;
			end
			START: begin
				count_start = 1'b1;
			end
			ACCUM: begin
				mac_ctrl.accumulate = 1'b1;
			end
			OUT_REQ: begin
				out_req = 1'b1;
			end
			default: begin
			end
		endcase
	end

	// The consumer must have answered before the request is withdrawn.
	a_out_req_held: assert property (@(posedge clk) disable iff (reset)
		out_req && !out_ack |=> out_req)
		else $error("fir_control: out_req dropped before out_ack rose");

endmodule

// ==== fir_top.sv ====
module fir_top
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    in_req,
	output logic    in_ack,
	input  sample_t sample,
	output logic    out_req,
	input  logic    out_ack,
	output acc_t    result
);

	logic       shift_en;
	logic       count_start;
	logic       count_last;
	mac_ctrl_t  mac_ctrl;
	tap_idx_t   tap_index;
	tap_array_t taps;

	fir_control u_control (
		.clk         (clk),
		.reset       (reset),
		.in_req      (in_req),
		.in_ack      (in_ack),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.shift_en    (shift_en),
		.count_start (count_start),
		.count_last  (count_last),
		.mac_ctrl    (mac_ctrl)
	);

	tap_counter u_counter (
		.clk        (clk),
		.reset      (reset),
		.start      (count_start),
		.tap_index  (tap_index),
		.count_last (count_last)
	);

	// The sample is stable for as long as in_req is high, so the delay
	// line can take it straight from the port.
	tap_delay_line u_delay_line (
		.clk      (clk),
		.reset    (reset),
		.shift_en (shift_en),
		.sample   (sample),
		.taps     (taps)
	);

	mac_unit u_mac (
		.clk       (clk),
		.reset     (reset),
		.mac_ctrl  (mac_ctrl),
		.tap_index (tap_index),
		.taps      (taps),
		.result    (result)
	);

endmodule

// ==== tb_fir_top.sv ====
module tb_fir_top
	import fir_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int IMPULSE_LEN = NUM_TAPS;
	localparam int RANDOM_LEN = 200;
	localparam int NUM_SAMPLES = IMPULSE_LEN + RANDOM_LEN;
	localparam int MAX_CYCLES = 60 * NUM_SAMPLES + 200;
	localparam int MAX_ACK_DELAY = 20;

	logic    clk;
	logic    reset;
	logic    in_req;
	logic    in_ack;
	sample_t sample;
	logic    out_req;
	logic    out_ack;
	acc_t    result;

	int      error_count = 0;
	int      cycle_count = 0;
	int      results_taken;
	int      pending_results;
	sample_t hist [NUM_TAPS];
	acc_t    exp_result;
	logic    in_ack_d;
	logic    out_ack_d;

	fir_top dut0 (
		.clk     (clk),
		.reset   (reset),
		.in_req  (in_req),
		.in_ack  (in_ack),
		.sample  (sample),
		.out_req (out_req),
		.out_ack (out_ack),
		.result  (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Convolution of the accepted samples with the coefficient table.
	function automatic acc_t reference_sum(input sample_t h [NUM_TAPS]);
		acc_t sum;
		sum = '0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			sum += acc_t'(COEFS[k]) * acc_t'(h[k]);
		end
		return sum;
	endfunction

	always_comb begin
		exp_result = reference_sum(hist);
	end

	// Model of the filter history, advanced once per accepted sample.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hist <= '{default: '0};
			pending_results <= 0;
			results_taken <= 0;
			in_ack_d <= 1'b0;
			out_ack_d <= 1'b0;
		end else begin
			in_ack_d <= in_ack;
			out_ack_d <= out_ack;
			if (in_ack && !in_ack_d) begin
				for (int k = NUM_TAPS - 1; k > 0; k--) begin
					hist[k] <= hist[k-1];
				end
				hist[0] <= sample;
				pending_results <= pending_results + 1;
			end else if (!out_ack && out_ack_d) begin
				pending_results <= pending_results - 1;
				results_taken <= results_taken + 1;
			end
		end
	end

	a_result_value: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> result == exp_result)
		else begin
			$display("[FAIL] time %0t result: expected %0d, got %0d",
				$time, $sampled(exp_result), $sampled(result));
			error_count++;
		end

	a_one_result: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> pending_results == 1)
		else begin
			$display("A result was offered without exactly one sample waiting for it");
			error_count++;
		end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> in_req)
		else begin
			$display("in_ack rose while in_req was low");
			error_count++;
		end

	// The next sample may only be taken once the last result is gone.
	a_back_pressure: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> pending_results == 0 && !out_ack)
		else begin
			$display("in_ack rose before the previous result had been taken");
			error_count++;
		end

	a_out_req_held: assert property (@(posedge clk) disable iff (reset)
		out_req && !out_ack |=> out_req)
		else begin
			$display("out_req fell before out_ack rose");
			error_count++;
		end

	a_result_stable: assert property (@(posedge clk) disable iff (reset)
		out_req && $past(out_req) |-> $stable(result))
		else begin
			$display("result changed while out_req was high");
			error_count++;
		end

	task automatic send_sample(input sample_t value);
		@(posedge clk);
		#1;
		sample = value;
		in_req = 1'b1;
		do @(posedge clk); while (!in_ack);
		#1 in_req = 1'b0;
		do @(posedge clk); while (in_ack);
	endtask

	task automatic take_result(input int index, input int delay);
		do @(posedge clk); while (!out_req);
		// The first results after reset must replay the coefficient table.
		if (index < IMPULSE_LEN) begin
			assert (result == acc_t'(COEFS[index])) else begin
				$display("[FAIL] time %0t result: expected %0d, got %0d",
					$time, COEFS[index], result);
				error_count++;
			end
		end
		repeat (delay) @(posedge clk);
		#1 out_ack = 1'b1;
		do @(posedge clk); while (out_req);
		#1 out_ack = 1'b0;
	endtask

	task automatic produce_samples();
		sample_t value;
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			if (i == 0) begin
				value = sample_t'(1);
			end else if (i < IMPULSE_LEN) begin
				value = '0;
			end else begin
				value = sample_t'($urandom);
			end
			send_sample(value);
		end
	endtask

	task automatic consume_results();
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			take_result(i, $urandom % (MAX_ACK_DELAY + 1));
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with %0d results taken",
				cycle_count, results_taken);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h2edd_9d5f));
		reset = 1'b1;
		in_req = 1'b0;
		out_ack = 1'b0;
		sample = '0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		assert (!in_ack && !out_req) else begin
			$display("in_ack or out_req is high after reset");
			error_count++;
		end
		fork
			produce_samples();
			consume_results();
		join
		repeat (4) @(posedge clk);
		$display("Run finished: %0d results taken, %0d errors", results_taken, error_count);
		if (error_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== src.f ====
fir_pkg.sv
tap_delay_line.sv
tap_counter.sv
mac_unit.sv
fir_control.sv
fir_top.sv
tb_fir_top.sv

// ==== Makefile ====
# Verilator build and run for the FIR filter testbench.

VERILATOR ?= verilator
TOP       ?= tb_fir_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_TEXT ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
